/* sim.f */
+incdir+include
verilog/periph_pkg.sv
verilog/periph_bus_decoder.sv
verilog/uart_tx_regs.sv
verilog/qspi_tx_regs.sv
verilog/soc_periph_top.sv
bench/tb_soc_periph.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing -j 0
TOP       := tb_soc_periph
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_soc_periph.sv */
`include "periph_config.svh"

module tb_soc_periph
    import periph_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUS_TIMEOUT  = 100;
    localparam int LINE_TIMEOUT = 4000;

    logic         clk_i = 1'b0;
    logic         arst_n_i;
    axil_addr_t   awaddr_i;
    logic         awvalid_i;
    logic         awready_o;
    axil_data_t   wdata_i;
    logic [3:0]   wstrb_i;
    logic         wvalid_i;
    logic         wready_o;
    axil_resp_t   bresp_o;
    logic         bvalid_o;
    logic         bready_i;
    axil_addr_t   araddr_i;
    logic         arvalid_i;
    logic         arready_o;
    axil_data_t   rdata_o;
    axil_resp_t   rresp_o;
    logic         rvalid_o;
    logic         rready_i;
    logic         uart_tx_o;
    logic         qspi_sclk_o;
    logic         qspi_cs_n_o;
    qspi_nibble_t qspi_data_o;
    qspi_nibble_t qspi_data_oen_o;

    int          mismatch_count = 0;
    int          timeout_count  = 0;
    logic [31:0] lcg_state      = 32'h4224a429;

    always #2 clk_i = ~clk_i;

    soc_periph_top dut_i (.*);

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Window goes in bits 19..16 and the offset in bits 3..0
    function automatic axil_addr_t make_addr(win_t win, reg_off_t off);
        axil_addr_t addr;
        addr = '0;
        addr[`PERIPH_WIN_LSB +: $bits(win_t)] = win;
        addr[$bits(reg_off_t)-1:0] = off;
        return addr;
    endfunction

    task automatic report_mismatch(input string text);
        $display("MISMATCH at %0d ns: %s", $time, text);
        mismatch_count++;
    endtask

    task automatic note_timeout(input string text);
        $display("Timed out at %0d ns while %s", $time, text);
        timeout_count++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite transactions
    //////////////////////////////////////////////////////////////////////
    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output axil_resp_t resp);
        int cycles;
        cycles = 0;
        resp = 2'bxx;
        @(posedge clk_i);
        awaddr_i  <= addr;
        awvalid_i <= 1'b1;
        wdata_i   <= data;
        wstrb_i   <= 4'hf;
        wvalid_i  <= 1'b1;
        // Handshake happens on the edge where both readies are seen high
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!(awready_o && wready_o) && cycles < BUS_TIMEOUT);
        awvalid_i <= 1'b0;
        wvalid_i  <= 1'b0;
        if (!(awready_o && wready_o)) begin
            note_timeout("waiting for awready and wready");
        end else begin
            cycles = 0;
            do begin
                @(posedge clk_i);
                cycles++;
            end while (!bvalid_o && cycles < BUS_TIMEOUT);
            if (bvalid_o) begin
                resp = bresp_o;
            end else begin
                note_timeout("waiting for bvalid");
            end
        end
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output axil_resp_t resp);
        int cycles;
        cycles = 0;
        data = 'x;
        resp = 2'bxx;
        @(posedge clk_i);
        araddr_i  <= addr;
        arvalid_i <= 1'b1;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!arready_o && cycles < BUS_TIMEOUT);
        arvalid_i <= 1'b0;
        if (!arready_o) begin
            note_timeout("waiting for arready");
        end else begin
            cycles = 0;
            do begin
                @(posedge clk_i);
                cycles++;
            end while (!rvalid_o && cycles < BUS_TIMEOUT);
            if (rvalid_o) begin
                data = rdata_o;
                resp = rresp_o;
            end else begin
                note_timeout("waiting for rvalid");
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Line monitors
    //////////////////////////////////////////////////////////////////////

    // Samples each bit near its middle with div cycles per bit
    task automatic uart_capture(input int div, output uart_byte_t value);
        int         cycles;
        logic [9:0] bits;
        cycles = 0;
        value = '0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (uart_tx_o !== 1'b0 && cycles < LINE_TIMEOUT);
        if (uart_tx_o !== 1'b0) begin
            note_timeout("waiting for a UART start bit");
        end else begin
            repeat (div / 2) @(posedge clk_i);
            for (int i = 0; i < 10; i++) begin
                bits[i] = uart_tx_o;
                repeat (div) @(posedge clk_i);
            end
            if (bits[0] !== 1'b0) begin
                report_mismatch("UART start bit is not 0");
            end
            if (bits[9] !== 1'b1) begin
                report_mismatch("UART stop bit is not 1");
            end
            value = bits[8:1];
        end
    endtask

    // Takes one nibble per rising sclk and shifts it in from the right
    task automatic qspi_capture(output axil_data_t word, output int count);
        int   cycles;
        logic prev_sclk;
        cycles = 0;
        word = '0;
        count = 0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (qspi_cs_n_o !== 1'b0 && cycles < LINE_TIMEOUT);
        if (qspi_cs_n_o !== 1'b0) begin
            note_timeout("waiting for qspi_cs_n_o to fall");
        end else begin
            prev_sclk = qspi_sclk_o;
            while (qspi_cs_n_o === 1'b0 && cycles < LINE_TIMEOUT) begin
                if (qspi_data_oen_o !== 4'h0) begin
                    report_mismatch("qspi_data_oen_o not zero while cs_n is low");
                end
                if (qspi_sclk_o === 1'b1 && prev_sclk === 1'b0) begin
                    word = {word[27:0], qspi_data_o};
                    count++;
                end
                prev_sclk = qspi_sclk_o;
                @(posedge clk_i);
                cycles++;
            end
            if (qspi_cs_n_o !== 1'b1) begin
                note_timeout("waiting for qspi_cs_n_o to rise");
            end
        end
    endtask

    task automatic expect_lines_idle(input int cycles, input string where);
        int active;
        active = 0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            if (uart_tx_o !== 1'b1 || qspi_cs_n_o !== 1'b1 || qspi_sclk_o !== 1'b1) begin
                active++;
            end
        end
        if (active != 0) begin
            report_mismatch($sformatf("line activity in %0d cycles %s", active, where));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic verify_reset_state();
        axil_data_t data;
        axil_resp_t resp;
        if (uart_tx_o !== 1'b1 || qspi_cs_n_o !== 1'b1 || qspi_sclk_o !== 1'b1) begin
            report_mismatch("line outputs not idle after reset");
        end
        if (qspi_data_oen_o !== 4'hf || qspi_data_o !== 4'h0) begin
            report_mismatch($sformatf("qspi oen %h data %h after reset",
                                      qspi_data_oen_o, qspi_data_o));
        end
        if ({awready_o, wready_o, arready_o, bvalid_o, rvalid_o} !== 5'b0) begin
            report_mismatch("bus handshake outputs not low after reset");
        end
        axil_read(make_addr(`UART_WIN, `REG_CLKDIV), data, resp);
        if (resp !== `RESP_OKAY || data !== {16'h0, `UART_CLKDIV_RST}) begin
            report_mismatch($sformatf("UART CLKDIV read %h resp %0d", data, resp));
        end
        axil_read(make_addr(`QSPI_WIN, `REG_CLKDIV), data, resp);
        if (resp !== `RESP_OKAY || data !== {16'h0, `QSPI_CLKDIV_RST}) begin
            report_mismatch($sformatf("QSPI CLKDIV read %h resp %0d", data, resp));
        end
    endtask

    task automatic send_uart_frames();
        axil_data_t word;
        axil_data_t status;
        axil_resp_t wr_resp;
        axil_resp_t rd_resp;
        uart_byte_t sent;
        uart_byte_t got;
        axil_write(make_addr(`UART_WIN, `REG_CLKDIV), 32'd8, wr_resp);
        if (wr_resp !== `RESP_OKAY) begin
            report_mismatch("UART CLKDIV write not OKAY");
        end
        for (int n = 0; n < 4; n++) begin
            word = next_random();
            sent = word[7:0];
            fork
                begin
                    axil_write(make_addr(`UART_WIN, `REG_TXDATA), {24'h0, sent}, wr_resp);
                    axil_read(make_addr(`UART_WIN, `REG_STATUS), status, rd_resp);
                end
                uart_capture(8, got);
            join
            if (wr_resp !== `RESP_OKAY || rd_resp !== `RESP_OKAY || status !== 32'd1) begin
                report_mismatch($sformatf("UART busy %h after write, resp %0d/%0d",
                                          status, wr_resp, rd_resp));
            end
            if (got !== sent) begin
                report_mismatch($sformatf("UART frame %h, expected %h", got, sent));
            end
            axil_read(make_addr(`UART_WIN, `REG_STATUS), status, rd_resp);
            if (status !== 32'd0) begin
                report_mismatch($sformatf("UART busy %h after frame end", status));
            end
        end
    endtask

    task automatic send_qspi_words();
        axil_data_t sent;
        axil_data_t got;
        axil_resp_t resp;
        int         count;
        axil_write(make_addr(`QSPI_WIN, `REG_CLKDIV), 32'd3, resp);
        if (resp !== `RESP_OKAY) begin
            report_mismatch("QSPI CLKDIV write not OKAY");
        end
        for (int n = 0; n < 3; n++) begin
            sent = next_random();
            fork
                axil_write(make_addr(`QSPI_WIN, `REG_TXDATA), sent, resp);
                qspi_capture(got, count);
            join
            if (resp !== `RESP_OKAY) begin
                report_mismatch($sformatf("QSPI TXDATA write resp %0d", resp));
            end
            if (count != 8 || got !== sent) begin
                report_mismatch($sformatf("QSPI sent %h as %0d nibbles %h", sent, count, got));
            end
        end
    endtask

    task automatic ignore_busy_writes();
        axil_data_t first;
        axil_data_t got_word;
        axil_resp_t resp;
        uart_byte_t got_byte;
        int         count;
        first = next_random();
        // Second write lands in the middle of the frame
        fork
            begin
                axil_write(make_addr(`UART_WIN, `REG_TXDATA), {24'h0, first[7:0]}, resp);
                repeat (10) @(posedge clk_i);
                axil_write(make_addr(`UART_WIN, `REG_TXDATA), {24'h0, ~first[7:0]}, resp);
            end
            uart_capture(8, got_byte);
        join
        if (got_byte !== first[7:0]) begin
            report_mismatch($sformatf("UART busy write changed frame to %h", got_byte));
        end
        expect_lines_idle(40, "after ignored UART write");
        first = next_random();
        fork
            begin
                axil_write(make_addr(`QSPI_WIN, `REG_TXDATA), first, resp);
                repeat (10) @(posedge clk_i);
                axil_write(make_addr(`QSPI_WIN, `REG_TXDATA), ~first, resp);
            end
            qspi_capture(got_word, count);
        join
        if (count != 8 || got_word !== first) begin
            report_mismatch($sformatf("QSPI busy write gave %h, expected %h", got_word, first));
        end
        expect_lines_idle(40, "after ignored QSPI write");
    endtask

    task automatic probe_unmapped_window(input win_t win);
        axil_data_t data;
        axil_resp_t resp;
        axil_write(make_addr(win, `REG_TXDATA), 32'h0000_00a5, resp);
        if (resp !== `RESP_SLVERR) begin
            report_mismatch($sformatf("window %0d TXDATA write resp %0d", win, resp));
        end
        axil_write(make_addr(win, `REG_CLKDIV), 32'd1, resp);
        if (resp !== `RESP_SLVERR) begin
            report_mismatch($sformatf("window %0d CLKDIV write resp %0d", win, resp));
        end
        axil_read(make_addr(win, `REG_CLKDIV), data, resp);
        if (resp !== `RESP_SLVERR || data !== 32'h0) begin
            report_mismatch($sformatf("window %0d read %h resp %0d", win, data, resp));
        end
        expect_lines_idle(60, $sformatf("after window %0d access", win));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        arst_n_i  <= 1'b0;
        awaddr_i  <= '0;
        awvalid_i <= 1'b0;
        wdata_i   <= '0;
        wstrb_i   <= 4'h0;
        wvalid_i  <= 1'b0;
        bready_i  <= 1'b1;
        araddr_i  <= '0;
        arvalid_i <= 1'b0;
        rready_i  <= 1'b1;
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);

        verify_reset_state();
        send_uart_frames();
        send_qspi_words();
        ignore_busy_writes();
        probe_unmapped_window(4'd0);
        probe_unmapped_window(4'd3);

        $display("Summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog/soc_periph_top.sv */
module soc_periph_top
    import periph_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_n_i,

    // AXI4-Lite slave port
    input  axil_addr_t   awaddr_i,
    input  logic         awvalid_i,
    output logic         awready_o,
    input  axil_data_t   wdata_i,
    input  logic [3:0]   wstrb_i,
    input  logic         wvalid_i,
    output logic         wready_o,
    output axil_resp_t   bresp_o,
    output logic         bvalid_o,
    input  logic         bready_i,
    input  axil_addr_t   araddr_i,
    input  logic         arvalid_i,
    output logic         arready_o,
    output axil_data_t   rdata_o,
    output axil_resp_t   rresp_o,
    output logic         rvalid_o,
    input  logic         rready_i,

    // Peripheral pins
    output logic         uart_tx_o,
    output logic         qspi_sclk_o,
    output logic         qspi_cs_n_o,
    output qspi_nibble_t qspi_data_o,
    output qspi_nibble_t qspi_data_oen_o
);

    reg_off_t   reg_off;
    axil_data_t reg_wdata;
    logic       uart_wr;
    logic       qspi_wr;
    axil_data_t uart_rdata;
    axil_data_t qspi_rdata;

    periph_bus_decoder bus_decoder_i (
        .clk_i          ( clk_i         ),
        .arst_n_i       ( arst_n_i      ),
        .awaddr_i       ( awaddr_i      ),
        .awvalid_i      ( awvalid_i     ),
        .awready_o      ( awready_o     ),
        .wdata_i        ( wdata_i       ),
        .wstrb_i        ( wstrb_i       ),
        .wvalid_i       ( wvalid_i      ),
        .wready_o       ( wready_o      ),
        .bresp_o        ( bresp_o       ),
        .bvalid_o       ( bvalid_o      ),
        .bready_i       ( bready_i      ),
        .araddr_i       ( araddr_i      ),
        .arvalid_i      ( arvalid_i     ),
        .arready_o      ( arready_o     ),
        .rdata_o        ( rdata_o       ),
        .rresp_o        ( rresp_o       ),
        .rvalid_o       ( rvalid_o      ),
        .rready_i       ( rready_i      ),
        .reg_off_o      ( reg_off       ),
        .wdata_o        ( reg_wdata     ),
        .uart_wr_o      ( uart_wr       ),
        .qspi_wr_o      ( qspi_wr       ),
        .uart_rdata_i   ( uart_rdata    ),
        .qspi_rdata_i   ( qspi_rdata    )
    );

    // Window 1
    uart_tx_regs uart_i (
        .clk_i          ( clk_i         ),
        .arst_n_i       ( arst_n_i      ),
        .wr_i           ( uart_wr       ),
        .reg_off_i      ( reg_off       ),
        .wdata_i        ( reg_wdata     ),
        .rdata_o        ( uart_rdata    ),
        .uart_tx_o      ( uart_tx_o     )
    );

    // Window 2
    qspi_tx_regs qspi_i (
        .clk_i           ( clk_i           ),
        .arst_n_i        ( arst_n_i        ),
        .wr_i            ( qspi_wr         ),
        .reg_off_i       ( reg_off         ),
        .wdata_i         ( reg_wdata       ),
        .rdata_o         ( qspi_rdata      ),
        .qspi_sclk_o     ( qspi_sclk_o     ),
        .qspi_cs_n_o     ( qspi_cs_n_o     ),
        .qspi_data_o     ( qspi_data_o     ),
        .qspi_data_oen_o ( qspi_data_oen_o )
    );

endmodule

/* verilog/qspi_tx_regs.sv */
`include "periph_config.svh"

module qspi_tx_regs
    import periph_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_n_i,

    // Register access from the bus decoder
    input  logic         wr_i,
    input  reg_off_t     reg_off_i,
    input  axil_data_t   wdata_i,
    output axil_data_t   rdata_o,

    // Quad SPI pins, transmit only
    output logic         qspi_sclk_o,
    output logic         qspi_cs_n_o,
    output qspi_nibble_t qspi_data_o,
    output qspi_nibble_t qspi_data_oen_o
);

    qspi_state_e state_q;
    clkdiv_t     clkdiv_q;
    clkdiv_t     div_eff;
    clkdiv_t     half_cnt_q;
    logic [2:0]  nib_cnt_q;
    axil_data_t  word_q;
    logic        sclk_q;
    logic        busy;
    logic        half_end;
    logic        xfer_start;

    assign busy       = (state_q != QSPI_IDLE);
    assign xfer_start = wr_i && (reg_off_i == `REG_TXDATA) && !busy;

    // Divider of zero behaves as one
    assign div_eff  = (clkdiv_q == '0) ? clkdiv_t'(1) : clkdiv_q;
    assign half_end = (half_cnt_q >= div_eff - clkdiv_t'(1));

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clkdiv_q <= `QSPI_CLKDIV_RST;
        end else if (wr_i && (reg_off_i == `REG_CLKDIV)) begin
            clkdiv_q <= wdata_i[$bits(clkdiv_t)-1:0];
        end
    end

    always_comb begin
        case (reg_off_i)
            `REG_STATUS: rdata_o = {{($bits(axil_data_t)-1){1'b0}}, busy};
            `REG_CLKDIV: rdata_o = {{($bits(axil_data_t)-$bits(clkdiv_t)){1'b0}}, clkdiv_q};
            default:     rdata_o = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Nibble shifter and sclk generation
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= QSPI_IDLE;
            half_cnt_q <= '0;
            nib_cnt_q  <= '0;
            sclk_q     <= 1'b1;
        end else begin
            if (state_q == QSPI_IDLE || half_end) begin
                half_cnt_q <= '0;
            end else begin
                half_cnt_q <= half_cnt_q + clkdiv_t'(1);
            end

            case (state_q)
                QSPI_IDLE: begin
                    // First nibble is driven with sclk low
                    if (xfer_start) begin
                        state_q   <= QSPI_SHIFT;
                        sclk_q    <= 1'b0;
                        nib_cnt_q <= '0;
                    end
                end
                QSPI_SHIFT: begin
                    if (half_end) begin
                        if (!sclk_q) begin
                            sclk_q <= 1'b1;
                            if (nib_cnt_q == 3'd7) begin
                                state_q <= QSPI_DONE;
                            end else begin
                                nib_cnt_q <= nib_cnt_q + 3'd1;
                            end
                        end else begin
                            sclk_q <= 1'b0;
                        end
                    end
                end
                QSPI_DONE: begin
                    // Hold cs_n low for one more half period after the last edge
                    if (half_end) begin
                        state_q <= QSPI_IDLE;
                    end
                end
                default: state_q <= QSPI_IDLE;
            endcase
        end
    end

    // Next nibble moves up on the falling sclk edge
    always_ff @(posedge clk_i) begin
        if (xfer_start) begin
            word_q <= wdata_i;
        end else if (state_q == QSPI_SHIFT && half_end && sclk_q) begin
            word_q <= word_q << $bits(qspi_nibble_t);
        end
    end

    assign qspi_sclk_o     = sclk_q;
    assign qspi_cs_n_o     = !busy;
    assign qspi_data_oen_o = {$bits(qspi_nibble_t){!busy}};
    assign qspi_data_o     = busy ? word_q[$bits(axil_data_t)-1 -: $bits(qspi_nibble_t)]
                                  : '0;

endmodule

/* verilog/uart_tx_regs.sv */
`include "periph_config.svh"

module uart_tx_regs
    import periph_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    // Register access from the bus decoder
    input  logic        wr_i,
    input  reg_off_t    reg_off_i,
    input  axil_data_t  wdata_i,
    output axil_data_t  rdata_o,

    // Serial line
    output logic        uart_tx_o
);

    uart_state_e state_q;
    clkdiv_t     clkdiv_q;
    clkdiv_t     div_eff;
    clkdiv_t     bit_cnt_q;
    logic [2:0]  bit_idx_q;
    uart_byte_t  shift_q;
    logic        busy;
    logic        bit_end;
    logic        tx_start;

    assign busy     = (state_q != UART_IDLE);
    assign tx_start = wr_i && (reg_off_i == `REG_TXDATA) && !busy;

    // Divider of zero behaves as one
    assign div_eff = (clkdiv_q == '0) ? clkdiv_t'(1) : clkdiv_q;
    assign bit_end = (bit_cnt_q >= div_eff - clkdiv_t'(1));

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clkdiv_q <= `UART_CLKDIV_RST;
        end else if (wr_i && (reg_off_i == `REG_CLKDIV)) begin
            clkdiv_q <= wdata_i[$bits(clkdiv_t)-1:0];
        end
    end

    always_comb begin
        case (reg_off_i)
            `REG_STATUS: rdata_o = {{($bits(axil_data_t)-1){1'b0}}, busy};
            `REG_CLKDIV: rdata_o = {{($bits(axil_data_t)-$bits(clkdiv_t)){1'b0}}, clkdiv_q};
            default:     rdata_o = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // 8N1 serializer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= UART_IDLE;
            bit_cnt_q <= '0;
            bit_idx_q <= '0;
        end else begin
            // Bit timer runs only while a frame is on the line
            if (state_q == UART_IDLE || bit_end) begin
                bit_cnt_q <= '0;
            end else begin
                bit_cnt_q <= bit_cnt_q + clkdiv_t'(1);
            end

            case (state_q)
                UART_IDLE: begin
                    if (tx_start) begin
                        state_q <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        state_q   <= UART_DATA;
                        bit_idx_q <= '0;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= UART_STOP;
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        state_q <= UART_IDLE;
                    end
                end
                default: state_q <= UART_IDLE;
            endcase
        end
    end

    // LSB goes out first
    always_ff @(posedge clk_i) begin
        if (tx_start) begin
            shift_q <= wdata_i[$bits(uart_byte_t)-1:0];
        end else if (state_q == UART_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state_q)
            UART_START: uart_tx_o = 1'b0;
            UART_DATA:  uart_tx_o = shift_q[0];
            default:    uart_tx_o = 1'b1;
        endcase
    end

endmodule

/* verilog/periph_bus_decoder.sv */
`include "periph_config.svh"

module periph_bus_decoder
    import periph_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n_i,

    // AXI4-Lite write channels
    input  axil_addr_t  awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  axil_data_t  wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output axil_resp_t  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i,

    // AXI4-Lite read channels
    input  axil_addr_t  araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output axil_data_t  rdata_o,
    output axil_resp_t  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i,

    // Register side, shared by both peripherals
    output reg_off_t    reg_off_o,
    output axil_data_t  wdata_o,
    output logic        uart_wr_o,
    output logic        qspi_wr_o,
    input  axil_data_t  uart_rdata_i,
    input  axil_data_t  qspi_rdata_i
);

    bus_state_e state_q;
    bus_state_e state_d;
    logic       wr_go;
    logic       rd_go;
    win_t       aw_win;
    win_t       ar_win;
    logic       aw_mapped;
    logic       ar_mapped;
    axil_data_t rd_word;
    axil_resp_t resp_q;
    axil_data_t rdata_q;

    //////////////////////////////////////////////////////////////////////
    // Accept and decode
    //////////////////////////////////////////////////////////////////////

    // Write wins when both arrive in the same cycle
    assign wr_go = (state_q == BUS_IDLE) && awvalid_i && wvalid_i;
    assign rd_go = (state_q == BUS_IDLE) && arvalid_i && !wr_go;

    assign awready_o = wr_go;
    assign wready_o  = wr_go;
    assign arready_o = rd_go;

    assign aw_win = awaddr_i[`PERIPH_WIN_LSB +: $bits(win_t)];
    assign ar_win = araddr_i[`PERIPH_WIN_LSB +: $bits(win_t)];

    assign aw_mapped = (aw_win == `UART_WIN) || (aw_win == `QSPI_WIN);
    assign ar_mapped = (ar_win == `UART_WIN) || (ar_win == `QSPI_WIN);

    // Offset follows whichever address is being taken this cycle
    assign reg_off_o = wr_go ? awaddr_i[$bits(reg_off_t)-1:0]
                             : araddr_i[$bits(reg_off_t)-1:0];
    assign wdata_o   = wdata_i;

    assign uart_wr_o = wr_go && (aw_win == `UART_WIN);
    assign qspi_wr_o = wr_go && (aw_win == `QSPI_WIN);

    // Read data of the addressed window, zero elsewhere
    always_comb begin
        case (ar_win)
            `UART_WIN: rd_word = uart_rdata_i;
            `QSPI_WIN: rd_word = qspi_rdata_i;
            default:   rd_word = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Response FSM
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            BUS_IDLE: begin
                if (wr_go) begin
                    state_d = BUS_WRESP;
                end else if (rd_go) begin
                    state_d = BUS_RRESP;
                end
            end
            BUS_WRESP: begin
                if (bready_i) begin
                    state_d = BUS_IDLE;
                end
            end
            BUS_RRESP: begin
                if (rready_i) begin
                    state_d = BUS_IDLE;
                end
            end
            default: state_d = BUS_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= BUS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // One response register serves both channels, only one is ever open
    always_ff @(posedge clk_i) begin
        if (wr_go) begin
            resp_q <= aw_mapped ? `RESP_OKAY : `RESP_SLVERR;
        end else if (rd_go) begin
            resp_q  <= ar_mapped ? `RESP_OKAY : `RESP_SLVERR;
            rdata_q <= rd_word;
        end
    end

    assign bvalid_o = (state_q == BUS_WRESP);
    assign bresp_o  = resp_q;
    assign rvalid_o = (state_q == BUS_RRESP);
    assign rresp_o  = resp_q;
    assign rdata_o  = rdata_q;

endmodule

/* verilog/periph_pkg.sv */
package periph_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus vectors
    //////////////////////////////////////////////////////////////////////
    typedef logic [19:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    // Address bits 3..0 and 19..16
    typedef logic [3:0]  reg_off_t;
    typedef logic [3:0]  win_t;

    //////////////////////////////////////////////////////////////////////
    // Peripheral vectors
    //////////////////////////////////////////////////////////////////////
    typedef logic [7:0]  uart_byte_t;
    typedef logic [3:0]  qspi_nibble_t;
    typedef logic [15:0] clkdiv_t;

    //////////////////////////////////////////////////////////////////////
    // FSM encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {BUS_IDLE, BUS_WRESP, BUS_RRESP} bus_state_e;

    typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;

    typedef enum logic [1:0] {QSPI_IDLE, QSPI_SHIFT, QSPI_DONE} qspi_state_e;

endpackage

/* include/periph_config.svh */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Window field in the bus address
`define PERIPH_WIN_LSB      16
`define UART_WIN            4'd1
`define QSPI_WIN            4'd2

// Register offsets, same layout in every window
`define REG_TXDATA          4'h0
`define REG_STATUS          4'h4
`define REG_CLKDIV          4'h8

// AXI response codes
`define RESP_OKAY           2'b00
`define RESP_SLVERR         2'b10

// Divider values after reset
`define UART_CLKDIV_RST     16'd16
`define QSPI_CLKDIV_RST     16'd2

`endif
